// ==== src/aluPkg.sv ====
`default_nettype none

package aluPkg;

    localparam int NumLanes   = 4;
    localparam int DataWidth  = 32;
    localparam int ShamtWidth = 5;  // shift amount comes from b[4:0]

    // bit 3 is the modifier, bits 2:0 pick the result source
    typedef enum logic [3:0] {
        opAdd   = 4'b0000,
        opSub   = 4'b1000,
        opSll   = 4'b0001,
        opSlt   = 4'b0010,
        opSltu  = 4'b1010,
        opPassB = 4'b0011,
        opXor   = 4'b0100,
        opSrl   = 4'b0101,
        opSra   = 4'b1101,
        opOr    = 4'b0110,
        opAnd   = 4'b0111
    } aluOp_e;

    // encoding matches the low three bits of the opcode
    typedef enum logic [2:0] {
        selAdder      = 3'b000,
        selShiftLeft  = 3'b001,
        selSetLess    = 3'b010,
        selOperandB   = 3'b011,
        selLogicXor   = 3'b100,
        selShiftRight = 3'b101,
        selLogicOr    = 3'b110,
        selLogicAnd   = 3'b111
    } resultSel_e;

endpackage

`default_nettype wire

// ==== src/barrelShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
    input  wire logic [aluPkg::DataWidth-1:0]  din,
    input  wire logic [aluPkg::ShamtWidth-1:0] shamt,
    input  wire logic                          shiftRight,
    input  wire logic                          shiftArith,
    output logic [aluPkg::DataWidth-1:0]       shifted
);

    logic [aluPkg::DataWidth-1:0] stage [aluPkg::ShamtWidth+1];
    logic                         fill;

    function automatic logic [aluPkg::DataWidth-1:0] bitReverse(
        input logic [aluPkg::DataWidth-1:0] value
    );
        logic [aluPkg::DataWidth-1:0] rev;
        for (int i = 0; i < aluPkg::DataWidth; i++) begin
            rev[i] = value[aluPkg::DataWidth-1-i];
        end
        return rev;
    endfunction

    // left shifts reuse the right-shift network on the reversed word
    assign stage[0] = shiftRight ? din : bitReverse(din);
    assign fill     = shiftRight & shiftArith & din[aluPkg::DataWidth-1];

    for (genvar lvl = 0; lvl < aluPkg::ShamtWidth; lvl++) begin : gLevel
        assign stage[lvl+1] = shamt[lvl]
            ? {{(1 << lvl){fill}}, stage[lvl][aluPkg::DataWidth-1:(1 << lvl)]}
            : stage[lvl];
    end

    assign shifted = shiftRight ? stage[aluPkg::ShamtWidth]
                                : bitReverse(stage[aluPkg::ShamtWidth]);  // undo the reversal

endmodule

`default_nettype wire

// ==== src/opDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module opDecoder (
    input  wire logic                                           clk,
    input  wire logic                                           reset,
    input  wire logic                                           inValid,
    input  wire aluPkg::aluOp_e                                 op,
    input  wire logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]  inA,
    input  wire logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]  inB,
    output logic                                                decValid,
    output logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]       decA,
    output logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]       decB,
    output aluPkg::resultSel_e                                  resultSel,
    output logic                                                subtract,
    output logic                                                shiftRight,
    output logic                                                shiftArith,
    output logic                                                unsignedCmp
);

    aluPkg::resultSel_e nextSel;
    logic               nextSubtract;
    logic               nextShiftRight;
    logic               nextShiftArith;
    logic               nextUnsigned;

    always_comb begin
        nextSel        = aluPkg::resultSel_e'(op[2:0]);  // unknown codes fall back to the low bits
        nextSubtract   = 1'b0;
        nextShiftRight = 1'b0;
        nextShiftArith = 1'b0;
        nextUnsigned   = 1'b0;
        case (op)
            aluPkg::opSub,
            aluPkg::opSlt: begin
                nextSubtract = 1'b1;  // compares run through the adder as a - b
            end
            aluPkg::opSltu: begin
                nextSubtract = 1'b1;
                nextUnsigned = 1'b1;
            end
            aluPkg::opSrl: begin
                nextShiftRight = 1'b1;
            end
            aluPkg::opSra: begin
                nextShiftRight = 1'b1;
                nextShiftArith = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // one control word is registered here and shared by every lane
    always_ff @(posedge clk) begin
        if (reset) begin
            decValid    <= 1'b0;
            decA        <= '0;
            decB        <= '0;
            resultSel   <= aluPkg::selAdder;
            subtract    <= 1'b0;
            shiftRight  <= 1'b0;
            shiftArith  <= 1'b0;
            unsignedCmp <= 1'b0;
        end else begin
            decValid <= inValid;
            if (inValid) begin
                decA        <= inA;
                decB        <= inB;
                resultSel   <= nextSel;
                subtract    <= nextSubtract;
                shiftRight  <= nextShiftRight;
                shiftArith  <= nextShiftArith;
                unsignedCmp <= nextUnsigned;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/aluLane.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluLane (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire logic                         decValid,
    input  wire logic [aluPkg::DataWidth-1:0] a,
    input  wire logic [aluPkg::DataWidth-1:0] b,
    input  wire aluPkg::resultSel_e           resultSel,
    input  wire logic                         subtract,
    input  wire logic                         shiftRight,
    input  wire logic                         shiftArith,
    input  wire logic                         unsignedCmp,
    output logic [aluPkg::DataWidth-1:0]      laneResult,
    output logic                              laneLess,
    output logic                              laneZero,
    output logic                              laneDone
);

    localparam int Msb = aluPkg::DataWidth - 1;

    logic [aluPkg::DataWidth-1:0] bOperand;
    logic [aluPkg::DataWidth-1:0] sum;
    logic                         carryOut;
    logic                         overflow;
    logic                         less;
    logic                         zero;
    logic [aluPkg::DataWidth-1:0] shifterOut;
    logic [aluPkg::DataWidth-1:0] result;

    // invert b and carry in one to get a - b
    assign bOperand          = b ^ {aluPkg::DataWidth{subtract}};
    assign {carryOut, sum}   = {1'b0, a} + {1'b0, bOperand} + {{aluPkg::DataWidth{1'b0}}, subtract};
    assign overflow          = (a[Msb] == bOperand[Msb]) && (a[Msb] != sum[Msb]);
    assign zero              = ~(|sum);
    assign less              = unsignedCmp ? ~carryOut : (sum[Msb] ^ overflow);  // no borrow means a >= b

    barrelShifter shifter_inst (
        .din        (a),
        .shamt      (b[aluPkg::ShamtWidth-1:0]),
        .shiftRight (shiftRight),
        .shiftArith (shiftArith),
        .shifted    (shifterOut)
    );

    always_comb begin
        case (resultSel)
            aluPkg::selAdder:      result = sum;
            aluPkg::selShiftLeft:  result = shifterOut;
            aluPkg::selSetLess:    result = {{Msb{1'b0}}, less};
            aluPkg::selOperandB:   result = b;
            aluPkg::selLogicXor:   result = a ^ b;
            aluPkg::selShiftRight: result = shifterOut;  // direction already set by shiftRight
            aluPkg::selLogicOr:    result = a | b;
            aluPkg::selLogicAnd:   result = a & b;
            default:               result = sum;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            laneDone   <= 1'b0;
            laneResult <= '0;
            laneLess   <= 1'b0;
            laneZero   <= 1'b0;
        end else begin
            laneDone <= decValid;
            if (decValid) begin
                laneResult <= result;
                laneLess   <= less;
                laneZero   <= zero;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/laneCollector.sv ====
`timescale 1ns/1ps
`default_nettype none

module laneCollector (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] laneResult,
    input  wire logic [aluPkg::NumLanes-1:0]                   laneLess,
    input  wire logic [aluPkg::NumLanes-1:0]                   laneZero,
    input  wire logic [aluPkg::NumLanes-1:0]                   laneDone,
    output logic                                               outValid,
    output logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]      outResult,
    output logic [aluPkg::NumLanes-1:0]                        lessMask,
    output logic [aluPkg::NumLanes-1:0]                        zeroMask,
    output logic                                               allZero
);

    logic allDone;

    // lanes run in lockstep, so all of them finish on the same edge
    assign allDone = &laneDone;

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid  <= 1'b0;
            outResult <= '0;
            lessMask  <= '0;
            zeroMask  <= '0;
            allZero   <= 1'b0;
        end else begin
            outValid <= allDone;
            if (allDone) begin
                outResult <= laneResult;
                lessMask  <= laneLess;
                zeroMask  <= laneZero;
                allZero   <= &laneZero;  // after sub this is a whole-vector equal compare
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/simdAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module simdAlu (
    input  wire logic                                          clk,
    input  wire logic                                          reset,
    input  wire logic                                          inValid,
    input  wire aluPkg::aluOp_e                                op,
    input  wire logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] inA,
    input  wire logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] inB,
    output logic                                               outValid,
    output logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0]      outResult,
    output logic [aluPkg::NumLanes-1:0]                        lessMask,
    output logic [aluPkg::NumLanes-1:0]                        zeroMask,
    output logic                                               allZero
);

    logic                                          decValid;
    logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] decA;
    logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] decB;
    aluPkg::resultSel_e                            resultSel;
    logic                                          subtract;
    logic                                          shiftRight;
    logic                                          shiftArith;
    logic                                          unsignedCmp;

    logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] laneResult;
    logic [aluPkg::NumLanes-1:0]                   laneLess;
    logic [aluPkg::NumLanes-1:0]                   laneZero;
    logic [aluPkg::NumLanes-1:0]                   laneDone;

    opDecoder opDecoder_inst (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .op          (op),
        .inA         (inA),
        .inB         (inB),
        .decValid    (decValid),
        .decA        (decA),
        .decB        (decB),
        .resultSel   (resultSel),
        .subtract    (subtract),
        .shiftRight  (shiftRight),
        .shiftArith  (shiftArith),
        .unsignedCmp (unsignedCmp)
    );

    // every lane sees the same control word and its own operand slice
    for (genvar lane = 0; lane < aluPkg::NumLanes; lane++) begin : gLane
        aluLane aluLane_inst (
            .clk         (clk),
            .reset       (reset),
            .decValid    (decValid),
            .a           (decA[lane*aluPkg::DataWidth +: aluPkg::DataWidth]),
            .b           (decB[lane*aluPkg::DataWidth +: aluPkg::DataWidth]),
            .resultSel   (resultSel),
            .subtract    (subtract),
            .shiftRight  (shiftRight),
            .shiftArith  (shiftArith),
            .unsignedCmp (unsignedCmp),
            .laneResult  (laneResult[lane*aluPkg::DataWidth +: aluPkg::DataWidth]),
            .laneLess    (laneLess[lane]),
            .laneZero    (laneZero[lane]),
            .laneDone    (laneDone[lane])
        );
    end

    laneCollector laneCollector_inst (
        .clk        (clk),
        .reset      (reset),
        .laneResult (laneResult),
        .laneLess   (laneLess),
        .laneZero   (laneZero),
        .laneDone   (laneDone),
        .outValid   (outValid),
        .outResult  (outResult),
        .lessMask   (lessMask),
        .zeroMask   (zeroMask),
        .allZero    (allZero)
    );

endmodule

`default_nettype wire

// ==== dv/aluRefModel.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// sub, slt and sltu run the adder as a - b, every other opcode as a + b
function automatic logic usesSubtract(input aluPkg::aluOp_e opCode);
    case (opCode)
        aluPkg::opSub, aluPkg::opSlt, aluPkg::opSltu: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic refLess(
    input aluPkg::aluOp_e               opCode,
    input logic [aluPkg::DataWidth-1:0] a,
    input logic [aluPkg::DataWidth-1:0] b
);
    if (opCode == aluPkg::opSltu) begin
        return a < b;
    end
    return $signed(a) < $signed(b);  // slt and sub compare as signed
endfunction

function automatic logic refZero(
    input aluPkg::aluOp_e               opCode,
    input logic [aluPkg::DataWidth-1:0] a,
    input logic [aluPkg::DataWidth-1:0] b
);
    logic [aluPkg::DataWidth-1:0] sum;
    sum = usesSubtract(opCode) ? a - b : a + b;
    return sum == '0;
endfunction

function automatic logic [aluPkg::DataWidth-1:0] refResult(
    input aluPkg::aluOp_e               opCode,
    input logic [aluPkg::DataWidth-1:0] a,
    input logic [aluPkg::DataWidth-1:0] b
);
    logic [aluPkg::ShamtWidth-1:0] shamt;
    shamt = b[aluPkg::ShamtWidth-1:0];
    case (opCode)
        aluPkg::opAdd:   return a + b;
        aluPkg::opSub:   return a - b;
        aluPkg::opSll:   return a << shamt;
        aluPkg::opSlt,
        aluPkg::opSltu:  return {{(aluPkg::DataWidth-1){1'b0}}, refLess(opCode, a, b)};
        aluPkg::opPassB: return b;
        aluPkg::opXor:   return a ^ b;
        aluPkg::opSrl:   return a >> shamt;
        aluPkg::opSra:   return $signed(a) >>> shamt;
        aluPkg::opOr:    return a | b;
        aluPkg::opAnd:   return a & b;
        default:         return '0;
    endcase
endfunction

`endif

// ==== dv/simdAluTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module simdAluTb;

    localparam int NumDirected   = 16;
    localparam int NumBurst      = 20;
    localparam int NumGaps       = 4;
    localparam int TotalIssues   = NumDirected + NumBurst + NumGaps;
    localparam int TimeoutCycles = 4 * TotalIssues + 50;

    typedef logic [aluPkg::NumLanes*aluPkg::DataWidth-1:0] laneVec_t;

    typedef struct packed {
        laneVec_t                    result;
        logic [aluPkg::NumLanes-1:0] less;
        logic [aluPkg::NumLanes-1:0] zero;
        logic                        checkLess;
        logic                        allZero;
        logic [31:0]                 issueCycle;
    } expect_t;

    logic                        clk;
    logic                        reset;
    logic                        inValid;
    aluPkg::aluOp_e              op;
    laneVec_t                    inA;
    laneVec_t                    inB;
    logic                        outValid;
    laneVec_t                    outResult;
    logic [aluPkg::NumLanes-1:0] lessMask;
    logic [aluPkg::NumLanes-1:0] zeroMask;
    logic                        allZero;

    expect_t                     expectQ[$];
    expect_t                     popped;
    logic [31:0]                 cycleCount;
    logic [31:0]                 lfsrState;
    int                          issuedCount;
    int                          pulseCount;
    int                          valueErrors;
    int                          protocolErrors;
    laneVec_t                    heldResult;
    logic [aluPkg::NumLanes-1:0] heldLess;
    logic [aluPkg::NumLanes-1:0] heldZero;
    logic                        heldAllZero;

    `include "aluRefModel.svh"

    simdAlu simdAlu_inst (
        .clk       (clk),
        .reset     (reset),
        .inValid   (inValid),
        .op        (op),
        .inA       (inA),
        .inB       (inB),
        .outValid  (outValid),
        .outResult (outResult),
        .lessMask  (lessMask),
        .zeroMask  (zeroMask),
        .allZero   (allZero)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // right-shifting galois form
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
        return w;
    endfunction

    function automatic laneVec_t randVec();
        laneVec_t v;
        for (int i = 0; i < aluPkg::NumLanes; i++) begin
            v[i*aluPkg::DataWidth +: aluPkg::DataWidth] = randBits(aluPkg::DataWidth);
        end
        return v;
    endfunction

    function automatic aluPkg::aluOp_e pickOp(input int idx);
        case (idx)
            0:       return aluPkg::opAdd;
            1:       return aluPkg::opSub;
            2:       return aluPkg::opSll;
            3:       return aluPkg::opSlt;
            4:       return aluPkg::opSltu;
            5:       return aluPkg::opPassB;
            6:       return aluPkg::opXor;
            7:       return aluPkg::opSrl;
            8:       return aluPkg::opSra;
            9:       return aluPkg::opOr;
            default: return aluPkg::opAnd;
        endcase
    endfunction

    task automatic reportValue(input string what, input laneVec_t got, input laneVec_t want);
        valueErrors++;
        $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
    endtask

    task automatic issue(input aluPkg::aluOp_e opCode, input laneVec_t a, input laneVec_t b);
        expect_t e;
        @(posedge clk);
        #1;
        inValid = 1'b1;
        op      = opCode;
        inA     = a;
        inB     = b;
        for (int i = 0; i < aluPkg::NumLanes; i++) begin
            e.result[i*aluPkg::DataWidth +: aluPkg::DataWidth] = refResult(opCode,
                a[i*aluPkg::DataWidth +: aluPkg::DataWidth],
                b[i*aluPkg::DataWidth +: aluPkg::DataWidth]);
            e.less[i] = refLess(opCode, a[i*aluPkg::DataWidth +: aluPkg::DataWidth],
                b[i*aluPkg::DataWidth +: aluPkg::DataWidth]);
            e.zero[i] = refZero(opCode, a[i*aluPkg::DataWidth +: aluPkg::DataWidth],
                b[i*aluPkg::DataWidth +: aluPkg::DataWidth]);
        end
        e.checkLess  = usesSubtract(opCode);  // less only means something for sub, slt and sltu
        e.allZero    = &e.zero;
        e.issueCycle = cycleCount;
        expectQ.push_back(e);
        issuedCount++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            inValid = 1'b0;
        end
    endtask

    task automatic checkPulse(input expect_t e);
        assert (outResult == e.result) else reportValue("outResult", outResult, e.result);
        assert (zeroMask == e.zero) else reportValue("zeroMask", zeroMask, e.zero);
        assert (allZero == e.allZero) else reportValue("allZero", allZero, e.allZero);
        if (e.checkLess) begin
            assert (lessMask == e.less) else reportValue("lessMask", lessMask, e.less);
        end
        assert (cycleCount - e.issueCycle == 3) else begin
            protocolErrors++;
            $display("result at %0t ns came %0d edges after its issue instead of 3",
                $time, cycleCount - e.issueCycle);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // outputs are sampled on the falling edge, well away from the drive time
    always @(negedge clk) begin
        if (!reset) begin
            if (pulseCount == 0 && !outValid) begin
                assert (allZero == 1'b0) else reportValue("allZero before any result", allZero, 0);
            end
            if (outValid) begin
                pulseCount++;
                if (expectQ.size() == 0) begin
                    protocolErrors++;
                    $display("unexpected output pulse at %0t ns with nothing outstanding", $time);
                end else begin
                    popped = expectQ.pop_front();
                    checkPulse(popped);
                end
                heldResult  = outResult;
                heldLess    = lessMask;
                heldZero    = zeroMask;
                heldAllZero = allZero;
            end else begin
                assert (outResult == heldResult)
                    else reportValue("outResult between pulses", outResult, heldResult);
                assert ({lessMask, zeroMask, allZero} == {heldLess, heldZero, heldAllZero})
                    else reportValue("flags between pulses", {lessMask, zeroMask, allZero},
                        {heldLess, heldZero, heldAllZero});
            end
        end
    end

    initial begin
        laneVec_t a;
        laneVec_t b;
        clk            = 1'b0;
        reset          = 1'b1;
        inValid        = 1'b0;
        op             = aluPkg::opAdd;
        inA            = '0;
        inB            = '0;
        cycleCount    <= '0;
        lfsrState      = 32'h7047_7c71;
        issuedCount    = 0;
        pulseCount     = 0;
        valueErrors    = 0;
        protocolErrors = 0;
        heldResult     = '0;
        heldLess       = '0;
        heldZero       = '0;
        heldAllZero    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        idle(5);

        a = {randBits(32), 32'h8000_0000, 32'hffff_ffff, 32'h0000_0000};
        b = {randBits(32), 32'h8000_0000, 32'h0000_0001, 32'h0000_0000};
        issue(aluPkg::opAdd, a, b);
        issue(aluPkg::opSub, a, b);
        a = randVec();
        issue(aluPkg::opSub, a, a);  // equal pairs in every lane

        a = {randBits(32), randBits(32), 32'hffff_ffff, 32'h0000_0000};
        b = randVec();
        issue(aluPkg::opXor, a, b);
        issue(aluPkg::opOr, a, b);
        issue(aluPkg::opAnd, a, b);
        issue(aluPkg::opPassB, a, b);

        // shift amounts 31 and 0, the last with upper bits of b set
        a = {randBits(32), 32'hffff_ffff, 32'h8000_0000, 32'h8000_0000};
        b = {randBits(32), 32'hffff_ffe0, 32'h0000_0000, 32'h0000_001f};
        issue(aluPkg::opSll, a, b);
        issue(aluPkg::opSrl, a, b);
        issue(aluPkg::opSra, a, b);
        a = randVec();
        b = randVec();
        issue(aluPkg::opSll, a, b);
        issue(aluPkg::opSrl, a, b);
        issue(aluPkg::opSra, a, b);

        // signed and unsigned order disagree in every lane
        a = {32'h7fff_ffff, 32'h0000_0000, 32'h0000_0001, 32'h8000_0000};
        b = {32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001};
        issue(aluPkg::opSlt, a, b);
        issue(aluPkg::opSltu, a, b);
        issue(aluPkg::opSub, a, b);
        idle(4);

        for (int i = 0; i < NumBurst; i++) begin
            issue(pickOp(randBits(4) % 11), randVec(), randVec());
        end
        idle(2);

        for (int i = 0; i < NumGaps; i++) begin
            issue(pickOp(randBits(4) % 11), randVec(), randVec());
            idle(1 + 2 * i);
        end

        while (expectQ.size() != 0) begin
            @(posedge clk);
        end
        idle(4);

        if (pulseCount != issuedCount) begin
            protocolErrors++;
            $display("saw %0d result pulses for %0d issued operations", pulseCount, issuedCount);
        end
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+dv
src/aluPkg.sv
src/barrelShifter.sv
src/opDecoder.sv
src/aluLane.sv
src/laneCollector.sv
src/simdAlu.sv
dv/simdAluTb.sv
